/* lcl_wr_pkg.sv */
`default_nettype none

package lcl_wr_pkg;

    // Port widths
    localparam int ADDR_W   = 64;
    localparam int DATA_W   = 256;
    localparam int BE_W     = DATA_W / 8;
    localparam int ID_W     = 5;
    localparam int ENG_ID_W = 3;
    localparam int CTX_W    = 9;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [BE_W-1:0]     be_t;
    typedef logic [ID_W-1:0]     axi_id_t;
    typedef logic [ENG_ID_W-1:0] eng_id_t;
    typedef logic [CTX_W-1:0]    ctx_t;

    // One write beat, address and data travel together
    typedef struct packed {
        logic    valid;
        addr_t   ea;
        axi_id_t axi_id;
        be_t     be;
        logic    first;
        logic    last;
        data_t   data;
        ctx_t    ctx;
        logic    ctx_valid;
    } wr_beat_t;

    // One write response from the port
    typedef struct packed {
        logic    valid;
        axi_id_t axi_id;
        logic    code;
    } wr_rsp_t;

    // Current owner of the write port
    typedef enum logic [1:0] {
        OWN_NONE = 2'd0,
        OWN_CMP  = 2'd1,
        OWN_MM   = 2'd2,
        OWN_ST   = 2'd3
    } owner_e;

endpackage

`default_nettype wire

/* lcl_wr_grant_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module lcl_wr_grant_fsm
    import lcl_wr_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cmp_req,
    input  logic   mm_req,
    input  logic   st_req,
    input  logic   last_done,
    output owner_e owner
);

    owner_e owner_q;
    owner_e owner_d;

    // First requester in the given search order, or no owner at all
    function automatic owner_e pick_first(
        input logic   req_a,
        input owner_e own_a,
        input logic   req_b,
        input owner_e own_b,
        input logic   req_c,
        input owner_e own_c
    );
        owner_e sel;
        if (req_a) begin
            sel = own_a;
        end else if (req_b) begin
            sel = own_b;
        end else if (req_c) begin
            sel = own_c;
        end else begin
            sel = OWN_NONE;
        end
        return sel;
    endfunction

    // Next owner
    always_comb begin
        owner_d = owner_q;
        case (owner_q)
            OWN_NONE: begin
                // Idle port, fixed priority cmp > mm > st
                owner_d = pick_first(cmp_req, OWN_CMP,
                                     mm_req,  OWN_MM,
                                     st_req,  OWN_ST);
            end
            OWN_CMP: begin
                if (last_done) begin
                    owner_d = pick_first(mm_req,  OWN_MM,
                                         st_req,  OWN_ST,
                                         cmp_req, OWN_CMP);
                end
            end
            OWN_MM: begin
                if (last_done) begin
                    owner_d = pick_first(st_req,  OWN_ST,
                                         cmp_req, OWN_CMP,
                                         mm_req,  OWN_MM);
                end
            end
            OWN_ST: begin
                if (last_done) begin
                    owner_d = pick_first(cmp_req, OWN_CMP,
                                         mm_req,  OWN_MM,
                                         st_req,  OWN_ST);
                end
            end
            default: begin
                owner_d = OWN_NONE;
            end
        endcase
    end

    // Grant is held for the whole burst, it only moves after the last beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= owner_d;
        end
    end

    assign owner = owner_q;

endmodule

`default_nettype wire

/* lcl_wr_req_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module lcl_wr_req_mux
    import lcl_wr_pkg::*;
(
    input  owner_e   owner,
    input  wr_beat_t cmp_wr,
    input  wr_beat_t mm_wr,
    input  wr_beat_t st_wr,
    output wr_beat_t lcl_wr,
    input  logic     lcl_wr_ready,
    output logic     cmp_wr_ready,
    output logic     mm_wr_ready,
    output logic     st_wr_ready,
    output logic     last_done
);

    // Owner's beat to the port, nothing while the port is idle
    always_comb begin
        case (owner)
            OWN_CMP: lcl_wr = cmp_wr;
            OWN_MM:  lcl_wr = mm_wr;
            OWN_ST:  lcl_wr = st_wr;
            default: lcl_wr = '0;
        endcase
    end

    // Port ready goes back to the owner only
    always_comb begin
        cmp_wr_ready = 1'b0;
        mm_wr_ready  = 1'b0;
        st_wr_ready  = 1'b0;
        case (owner)
            OWN_CMP: cmp_wr_ready = lcl_wr_ready;
            OWN_MM:  mm_wr_ready  = lcl_wr_ready;
            OWN_ST:  st_wr_ready  = lcl_wr_ready;
            default: begin
                cmp_wr_ready = 1'b0;
                mm_wr_ready  = 1'b0;
                st_wr_ready  = 1'b0;
            end
        endcase
    end

    // Burst ends when the owner's last beat is accepted
    assign last_done = lcl_wr.valid && lcl_wr.last && lcl_wr_ready;

endmodule

`default_nettype wire

/* lcl_wr_rsp_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

module lcl_wr_rsp_dispatch
    import lcl_wr_pkg::*;
#(
    parameter eng_id_t CMP_ID = 3'd5,
    parameter eng_id_t MM_ID  = 3'd0,
    parameter eng_id_t ST_ID  = 3'd1
) (
    input  wr_rsp_t lcl_rsp,
    output logic    lcl_rsp_ready,
    output wr_rsp_t cmp_rsp,
    output wr_rsp_t mm_rsp,
    output wr_rsp_t st_rsp,
    input  logic    cmp_rsp_ready,
    input  logic    mm_rsp_ready,
    input  logic    st_rsp_ready
);

    eng_id_t rsp_eng;
    logic    hit_cmp;
    logic    hit_mm;
    logic    hit_st;

    // Engine field sits in the low bits of the AXI ID
    assign rsp_eng = lcl_rsp.axi_id[ENG_ID_W-1:0];

    assign hit_cmp = (rsp_eng == CMP_ID);
    assign hit_mm  = (rsp_eng == MM_ID);
    assign hit_st  = (rsp_eng == ST_ID);

    // Addressed engine sees the response as is, the others see zeros
    assign cmp_rsp = hit_cmp ? lcl_rsp : '0;
    assign mm_rsp  = hit_mm  ? lcl_rsp : '0;
    assign st_rsp  = hit_st  ? lcl_rsp : '0;

    // Ready from the addressed engine
    always_comb begin
        if (hit_cmp) begin
            lcl_rsp_ready = cmp_rsp_ready;
        end else if (hit_mm) begin
            lcl_rsp_ready = mm_rsp_ready;
        end else if (hit_st) begin
            lcl_rsp_ready = st_rsp_ready;
        end else begin
            // Unknown engine, drop the response rather than stall the port
            lcl_rsp_ready = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* lcl_wr_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module lcl_wr_arbiter
    import lcl_wr_pkg::*;
#(
    parameter eng_id_t CMP_ID = 3'd5,
    parameter eng_id_t MM_ID  = 3'd0,
    parameter eng_id_t ST_ID  = 3'd1
) (
    input  logic     clk,
    input  logic     rst_n,

    // Engine write beats
    input  wr_beat_t cmp_wr,
    output logic     cmp_wr_ready,
    input  wr_beat_t mm_wr,
    output logic     mm_wr_ready,
    input  wr_beat_t st_wr,
    output logic     st_wr_ready,

    // Local memory write port
    output wr_beat_t lcl_wr,
    input  logic     lcl_wr_ready,
    input  wr_rsp_t  lcl_rsp,
    output logic     lcl_rsp_ready,

    // Engine write responses
    output wr_rsp_t  cmp_rsp,
    input  logic     cmp_rsp_ready,
    output wr_rsp_t  mm_rsp,
    input  logic     mm_rsp_ready,
    output wr_rsp_t  st_rsp,
    input  logic     st_rsp_ready
);

    owner_e owner;
    logic   last_done;

    // Burst owner, engine valids are the requests
    lcl_wr_grant_fsm grant_fsm_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmp_req   (cmp_wr.valid),
        .mm_req    (mm_wr.valid),
        .st_req    (st_wr.valid),
        .last_done (last_done),
        .owner     (owner)
    );

    lcl_wr_req_mux req_mux_i (
        .owner        (owner),
        .cmp_wr       (cmp_wr),
        .mm_wr        (mm_wr),
        .st_wr        (st_wr),
        .lcl_wr       (lcl_wr),
        .lcl_wr_ready (lcl_wr_ready),
        .cmp_wr_ready (cmp_wr_ready),
        .mm_wr_ready  (mm_wr_ready),
        .st_wr_ready  (st_wr_ready),
        .last_done    (last_done)
    );

    // Response path is independent of the grant
    lcl_wr_rsp_dispatch #(
        .CMP_ID (CMP_ID),
        .MM_ID  (MM_ID),
        .ST_ID  (ST_ID)
    ) rsp_dispatch_i (
        .lcl_rsp       (lcl_rsp),
        .lcl_rsp_ready (lcl_rsp_ready),
        .cmp_rsp       (cmp_rsp),
        .mm_rsp        (mm_rsp),
        .st_rsp        (st_rsp),
        .cmp_rsp_ready (cmp_rsp_ready),
        .mm_rsp_ready  (mm_rsp_ready),
        .st_rsp_ready  (st_rsp_ready)
    );

endmodule

`default_nettype wire

/* tb_lcl_wr_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_lcl_wr_arbiter
    import lcl_wr_pkg::*;
;

    localparam eng_id_t CMP_ID = 3'd5;
    localparam eng_id_t MM_ID  = 3'd0;
    localparam eng_id_t ST_ID  = 3'd1;

    localparam int RR_BURSTS   = 12;
    localparam int MIX_BURSTS  = 36;
    localparam int RSP_COUNT   = 200;
    localparam int TOTAL_BEATS = 3 * (RR_BURSTS + MIX_BURSTS) * 4;

    logic     clk;
    logic     rst_n;
    wr_beat_t drv [3];
    logic     rdy [3];
    wr_beat_t cmp_wr, mm_wr, st_wr;
    logic     cmp_wr_ready, mm_wr_ready, st_wr_ready;
    wr_beat_t lcl_wr;
    logic     lcl_wr_ready;
    wr_rsp_t  lcl_rsp;
    logic     lcl_rsp_ready;
    wr_rsp_t  cmp_rsp, mm_rsp, st_rsp;
    logic     cmp_rsp_ready, mm_rsp_ready, st_rsp_ready;

    integer seed = 32'ha727f63f;
    int     beats_sent = 0;
    int     beats_seen = 0;
    int     seq_cnt [3];

    assign cmp_wr = drv[0];
    assign mm_wr  = drv[1];
    assign st_wr  = drv[2];
    assign rdy[0] = cmp_wr_ready;
    assign rdy[1] = mm_wr_ready;
    assign rdy[2] = st_wr_ready;

    lcl_wr_arbiter #(
        .CMP_ID (CMP_ID),
        .MM_ID  (MM_ID),
        .ST_ID  (ST_ID)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmp_wr        (cmp_wr),
        .cmp_wr_ready  (cmp_wr_ready),
        .mm_wr         (mm_wr),
        .mm_wr_ready   (mm_wr_ready),
        .st_wr         (st_wr),
        .st_wr_ready   (st_wr_ready),
        .lcl_wr        (lcl_wr),
        .lcl_wr_ready  (lcl_wr_ready),
        .lcl_rsp       (lcl_rsp),
        .lcl_rsp_ready (lcl_rsp_ready),
        .cmp_rsp       (cmp_rsp),
        .cmp_rsp_ready (cmp_rsp_ready),
        .mm_rsp        (mm_rsp),
        .mm_rsp_ready  (mm_rsp_ready),
        .st_rsp        (st_rsp),
        .st_rsp_ready  (st_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [383:0] exp,
                             input logic [383:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // Owner code 0 is none, 1 cmp, 2 mm and 3 st, and req bit 0 is cmp
    function automatic int next_owner(input int prev, input logic [2:0] req);
        int cand;
        for (int i = 1; i <= 3; i++) begin
            cand = ((prev + i - 1) % 3) + 1;
            if (req[cand-1]) begin
                return cand;
            end
        end
        return 0;
    endfunction

    // Data top bytes carry engine, sequence, beat index and burst length
    function automatic wr_beat_t make_beat(input int e, input int seq, input int idx,
                                           input int len);
        wr_beat_t b;
        b.valid     = 1'b1;
        b.ea        = {$random(seed), $random(seed)};
        b.axi_id    = 5'($random(seed));
        b.be        = 32'($random(seed));
        b.first     = (idx == 0);
        b.last      = (idx == len - 1);
        b.data      = {8'(e + 1), 16'(seq), 8'(idx), 8'(len),
                       216'({$random(seed), $random(seed), $random(seed), $random(seed),
                             $random(seed), $random(seed), $random(seed)})};
        b.ctx       = 9'($random(seed));
        b.ctx_valid = 1'($random(seed));
        return b;
    endfunction

    // One engine sends its bursts and starts the first one without a gap
    task automatic run_engine(input int e, input int n_bursts, input int max_gap);
        int gap;
        int len;
        for (int n = 0; n < n_bursts; n++) begin
            gap = (n == 0 || max_gap == 0) ? 0 : ($random(seed) & 32'h7fff) % (max_gap + 1);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            len = (($random(seed) & 32'h7fff) % 4) + 1;
            for (int idx = 0; idx < len; idx++) begin
                drv[e] = make_beat(e, seq_cnt[e], idx, len);
                do begin
                    @(negedge clk);
                end while (!rdy[e]);
                beats_sent++;
                @(posedge clk);
                #1;
            end
            drv[e] = '0;
            seq_cnt[e]++;
        end
    endtask

    // Port back-pressure
    initial begin
        forever begin
            @(posedge clk);
            #1;
            lcl_wr_ready = (($random(seed) & 3) != 0);
        end
    end

    // Reference owner model and beat compare at the falling edge
    initial begin
        int          model;
        int          eng;
        int          exp_seq [3];
        int          exp_idx [3];
        logic [2:0]  req;
        model = 0;
        for (int i = 0; i < 3; i++) begin
            exp_seq[i] = 0;
            exp_idx[i] = 0;
        end
        forever begin
            @(negedge clk);
            req = {st_wr.valid, mm_wr.valid, cmp_wr.valid};
            if (!rst_n || model == 0) begin
                check_val("idle_valid", 384'(0), 384'(lcl_wr.valid));
                check_val("idle_ready", 384'(0),
                          384'({cmp_wr_ready, mm_wr_ready, st_wr_ready}));
                if (rst_n) begin
                    model = next_owner(0, req);
                end
            end else begin
                check_val("owner_ready", 384'(lcl_wr_ready), 384'(rdy[model-1]));
                check_val("other_ready", 384'(0), 384'((cmp_wr_ready ? 1 : 0) +
                          (mm_wr_ready ? 1 : 0) + (st_wr_ready ? 1 : 0) -
                          (lcl_wr_ready ? 1 : 0)));
                if (lcl_wr.valid && lcl_wr_ready) begin
                    eng = int'(lcl_wr.data[255:248]);
                    check_val("owner", 384'(model), 384'(eng));
                    check_val("beat", 384'(drv[model-1]), 384'(lcl_wr));
                    check_val("seq", 384'(16'(exp_seq[model-1])),
                              384'(lcl_wr.data[247:232]));
                    check_val("beat_idx", 384'(8'(exp_idx[model-1])),
                              384'(lcl_wr.data[231:224]));
                    check_val("first", 384'(exp_idx[model-1] == 0), 384'(lcl_wr.first));
                    check_val("last", 384'(exp_idx[model-1] + 1 ==
                              int'(lcl_wr.data[223:216])), 384'(lcl_wr.last));
                    beats_seen++;
                    if (lcl_wr.last) begin
                        exp_seq[model-1]++;
                        exp_idx[model-1] = 0;
                        model = next_owner(model, req);
                    end else begin
                        exp_idx[model-1]++;
                    end
                end
            end
        end
    end

    // Random responses to the three engines and to unused identifiers
    task automatic check_responses(input int count);
        int      k;
        eng_id_t field;
        for (int n = 0; n < count; n++) begin
            @(posedge clk);
            #1;
            k = $random(seed) & 3;
            case (k)
                0: field = CMP_ID;
                1: field = MM_ID;
                2: field = ST_ID;
                default: begin
                    do begin
                        field = 3'($random(seed));
                    end while (field == CMP_ID || field == MM_ID || field == ST_ID);
                end
            endcase
            lcl_rsp.valid  = (($random(seed) & 7) != 0);
            lcl_rsp.axi_id = {2'($random(seed)), field};
            lcl_rsp.code   = 1'($random(seed));
            cmp_rsp_ready  = 1'($random(seed));
            mm_rsp_ready   = 1'($random(seed));
            st_rsp_ready   = 1'($random(seed));
            @(negedge clk);
            check_val("cmp_rsp", 384'(k == 0 ? lcl_rsp : '0), 384'(cmp_rsp));
            check_val("mm_rsp", 384'(k == 1 ? lcl_rsp : '0), 384'(mm_rsp));
            check_val("st_rsp", 384'(k == 2 ? lcl_rsp : '0), 384'(st_rsp));
            check_val("rsp_ready", 384'(k == 0 ? cmp_rsp_ready : k == 1 ? mm_rsp_ready :
                      k == 2 ? st_rsp_ready : 1'b1), 384'(lcl_rsp_ready));
        end
    endtask

    // Watchdog
    initial begin
        repeat (TOTAL_BEATS * 20) @(posedge clk);
        $display("ERROR: run did not finish within %0d cycles", TOTAL_BEATS * 20);
        $display("Result: FAILED");
        $fatal(1);
    end

    initial begin
        rst_n         = 1'b0;
        lcl_wr_ready  = 1'b0;
        lcl_rsp       = '0;
        cmp_rsp_ready = 1'b0;
        mm_rsp_ready  = 1'b0;
        st_rsp_ready  = 1'b0;
        // Every engine already offers a beat while reset is held
        for (int i = 0; i < 3; i++) begin
            drv[i]       = '0;
            drv[i].valid = 1'b1;
            drv[i].first = 1'b1;
            drv[i].last  = 1'b1;
            seq_cnt[i]   = 0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < 3; i++) begin
            drv[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        // Continuous requests from all engines give round robin between bursts
        fork
            run_engine(0, RR_BURSTS, 0);
            run_engine(1, RR_BURSTS, 0);
            run_engine(2, RR_BURSTS, 0);
        join
        repeat (5) @(posedge clk);
        #1;
        // All engines raise valid together after the idle gap and then leave random gaps
        fork
            run_engine(0, MIX_BURSTS, 3);
            run_engine(1, MIX_BURSTS, 3);
            run_engine(2, MIX_BURSTS, 3);
        join
        repeat (5) @(posedge clk);
        check_responses(RSP_COUNT);
        check_val("beat_count", 384'(beats_sent), 384'(beats_seen));
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
lcl_wr_pkg.sv
lcl_wr_grant_fsm.sv
lcl_wr_req_mux.sv
lcl_wr_rsp_dispatch.sv
lcl_wr_arbiter.sv
tb_lcl_wr_arbiter.sv

/* run.sh */
#!/bin/sh
# Compile and run the arbiter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f build.f \
    --top-module tb_lcl_wr_arbiter \
    -o sim_tb_lcl_wr_arbiter

./obj_dir/sim_tb_lcl_wr_arbiter
